// File: bank_regs.sv
`timescale 1ns/1ns
`default_nettype none

module bank_regs (
    input  wire                           clk6x,
    input  wire                           resetn,
    input  wire                           release_wr_i,
    // limits RAMBANK as used for addressing
    input  wire [bus_pkg::RAMBANK_W-1:0]  rambank_mask_i,
    // cpu write data, valid at release_wr
    input  wire [bus_pkg::RAMBANK_W-1:0]  wr_data_i,
    cpu_cycle_if.banks                    cyc,
    output logic [bus_pkg::RAMBANK_W-1:0] rambank_o,
    output logic [bus_pkg::ROMBANK_W-1:0] rombank_o,
    output logic [bus_pkg::RAMBANK_W-1:0] rambank_masked_o
);
    import bus_pkg::*;

    // write strobe for this cycle
    logic bank_wr;

    assign bank_wr = release_wr_i && cyc.req_bankreg && !cyc.slv_rwn;

    // register write at the end of the cpu cycle
    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            rambank_o <= '0;
            rombank_o <= '0;
        end
        else if (bank_wr)
        begin
            if (!cyc.slv_addr.flat.lo[0])
            begin
                // 0x0000 RAMBANK, full byte
                rambank_o <= wr_data_i;
            end
            else
            begin
                // 0x0001 ROMBANK, low bits only
                rombank_o <= wr_data_i[ROMBANK_W-1:0];
            end
        end
    end

    // masked bank ready ahead of the next decode
    always_ff @(posedge clk6x)
    begin
        rambank_masked_o <= rambank_o & rambank_mask_i;
    end

endmodule

`default_nettype wire

// File: bus_controller.sv
`timescale 1ns/1ns
`default_nettype none

module bus_controller (
    input  wire                            clk6x,
    input  wire                            resetn,
    // cpu bus
    input  wire  [7:0]                     cpu_db_i,
    input  wire  [3:0]                     cpu_abh_i,
    input  wire  [bus_pkg::CPU_ABL_W-1:0]  memcpu_abl_i,
    input  wire                            cpu_vpu_i,
    input  wire                            cpu_rw_i,
    input  wire  [7:0]                     mem_db_i,
    // clock phaser pulses
    input  wire                            setup_cs_i,
    input  wire                            release_wr_i,
    input  wire                            release_cs_i,
    // internal slave read data
    input  wire  [7:0]                     nora_slv_data_i,
    input  wire  [bus_pkg::RAMBANK_W-1:0]  rambank_mask_i,
    output wire  [7:0]                     cpu_db_o,
    // memory bus
    output wire  [bus_pkg::MEM_ABH_W-1:0]  mem_abh_o,
    output wire  [bus_pkg::CPU_ABL_W-1:0]  memcpu_abl_o,
    output wire  [7:0]                     mem_db_o,
    output wire                            mem_rdn_o,
    output wire                            mem_wrn_o,
    output wire                            sram_csn_o,
    output wire                            vera_csn_o,
    output wire                            aio_csn_o,
    output wire                            enet_csn_o,
    // internal slave side
    output wire  [15:0]                    nora_slv_addr_o,
    output wire  [7:0]                     nora_slv_datawr_o,
    output wire                            nora_slv_datawr_valid_o,
    output wire                            nora_slv_req_scrb_o,
    output wire                            nora_slv_req_via1_o,
    output wire                            nora_slv_rwn_o
);
    import bus_pkg::*;

    // full 16-bit cpu address from both halves
    cpu_addr_u            cpu_addr;
    logic [RAMBANK_W-1:0] rambank;
    logic [RAMBANK_W-1:0] rambank_masked;
    logic [ROMBANK_W-1:0] rombank;

    cpu_cycle_if cyc ();

    assign cpu_addr = {cpu_abh_i, memcpu_abl_i};

    // write data is only stable at the very end of the cycle, hence release_wr
    assign mem_db_o                = cpu_db_i;
    assign nora_slv_datawr_o       = cpu_db_i;
    assign nora_slv_datawr_valid_o = release_wr_i;

    // latched cycle state out to the slaves and memory
    assign nora_slv_addr_o = cyc.slv_addr;
    assign nora_slv_rwn_o  = cyc.slv_rwn;
    assign mem_rdn_o       = cyc.mem_rdn;

    cpu_addr_decoder cpu_addr_decoder_inst (
        .clk6x            (clk6x),
        .resetn           (resetn),
        .setup_cs_i       (setup_cs_i),
        .release_wr_i     (release_wr_i),
        .release_cs_i     (release_cs_i),
        .cpu_rw_i         (cpu_rw_i),
        .cpu_vpu_i        (cpu_vpu_i),
        .cpu_addr_i       (cpu_addr),
        .rombank_i        (rombank),
        .rambank_masked_i (rambank_masked),
        .mem_abh_o        (mem_abh_o),
        .memcpu_abl_o     (memcpu_abl_o),
        .sram_csn_o       (sram_csn_o),
        .vera_csn_o       (vera_csn_o),
        .aio_csn_o        (aio_csn_o),
        .enet_csn_o       (enet_csn_o),
        .mem_wrn_o        (mem_wrn_o),
        .req_scrb_o       (nora_slv_req_scrb_o),
        .req_via1_o       (nora_slv_req_via1_o),
        .cyc              (cyc.decoder)
    );

    bank_regs bank_regs_inst (
        .clk6x            (clk6x),
        .resetn           (resetn),
        .release_wr_i     (release_wr_i),
        .rambank_mask_i   (rambank_mask_i),
        .wr_data_i        (cpu_db_i),
        .cyc              (cyc.banks),
        .rambank_o        (rambank),
        .rombank_o        (rombank),
        .rambank_masked_o (rambank_masked)
    );

    cpu_read_path cpu_read_path_inst (
        .clk6x      (clk6x),
        .mem_db_i   (mem_db_i),
        .slv_data_i (nora_slv_data_i),
        .rambank_i  (rambank),
        .rombank_i  (rombank),
        .req_scrb_i (nora_slv_req_scrb_o),
        .req_via1_i (nora_slv_req_via1_o),
        .cyc        (cyc.reader),
        .cpu_db_o   (cpu_db_o)
    );

endmodule

`default_nettype wire

// File: bus_controller_chk.sv
`timescale 1ns/1ns
`default_nettype none

module bus_controller_chk (
    input wire clk6x,
    input wire resetn,
    input wire setup_cs_i,
    input wire release_cs_i,
    input wire sram_csn_i,
    input wire vera_csn_i,
    input wire aio_csn_i,
    input wire enet_csn_i,
    input wire mem_rdn_i,
    input wire mem_wrn_i,
    input wire req_scrb_i,
    input wire req_via1_i
);
    import bus_pkg::*;

    // failed assertions so far
    int         fail_count = 0;
    // selects driven active right now
    logic [2:0] cs_active;
    // bus fully released, nothing requested
    logic       all_idle;

    assign cs_active = (sram_csn_i == ACT_LOW) + (vera_csn_i == ACT_LOW)
                     + (aio_csn_i == ACT_LOW) + (enet_csn_i == ACT_LOW);
    assign all_idle  = (sram_csn_i == INACT_HIGH) && (vera_csn_i == INACT_HIGH)
                    && (aio_csn_i == INACT_HIGH) && (enet_csn_i == INACT_HIGH)
                    && (mem_rdn_i == INACT_HIGH) && (mem_wrn_i == INACT_HIGH)
                    && !req_scrb_i && !req_via1_i;

    // one device on the bus at a time
    assert property (@(posedge clk6x) disable iff (!resetn) cs_active <= 3'd1)
    else
    begin
        fail_count++;
        $error("more than one chip select active");
    end

    assert property (@(posedge clk6x) disable iff (!resetn)
                     !((mem_rdn_i == ACT_LOW) && (mem_wrn_i == ACT_LOW)))
    else
    begin
        fail_count++;
        $error("read and write strobes active together");
    end

    // release without a new setup leaves the bus idle
    assert property (@(posedge clk6x) disable iff (!resetn)
                     (release_cs_i && !setup_cs_i) |=> all_idle)
    else
    begin
        fail_count++;
        $error("bus not idle after release_cs");
    end

endmodule

bind bus_controller bus_controller_chk bus_controller_chk_inst (
    .clk6x        (clk6x),
    .resetn       (resetn),
    .setup_cs_i   (setup_cs_i),
    .release_cs_i (release_cs_i),
    .sram_csn_i   (sram_csn_o),
    .vera_csn_i   (vera_csn_o),
    .aio_csn_i    (aio_csn_o),
    .enet_csn_i   (enet_csn_o),
    .mem_rdn_i    (mem_rdn_o),
    .mem_wrn_i    (mem_wrn_o),
    .req_scrb_i   (nora_slv_req_scrb_o),
    .req_via1_i   (nora_slv_req_via1_o)
);

`default_nettype wire

// File: bus_pkg.sv
`default_nettype none

package bus_pkg;

    // levels of the active-low selects and strobes
    localparam logic ACT_LOW    = 1'b0;
    localparam logic INACT_HIGH = 1'b1;

    // top two bits of the memory high address for ROM banks
    localparam logic [1:0] ROM_BANK_TOP = 2'b11;

    // base low memory prefix, SRAM pages 0x170..0x17F
    localparam logic [4:0] LOWMEM_PAGE = 5'h17;

    // I/O page 0x9Fxx
    localparam logic [7:0] IO_PAGE = 8'h9F;

    // register-group nibbles inside the I/O page
    localparam logic [3:0] IO_VIA1 = 4'h0;
    localparam logic [3:0] IO_AURA = 4'h4;
    localparam logic [3:0] IO_SCRB = 4'h5;
    localparam logic [3:0] IO_ENET = 4'h8;
    // VERA spans 0x9F20..0x9F3F, so only the upper three group bits count
    localparam logic [2:0] IO_VERA_HI = 3'b001;

    // bank register widths
    localparam int RAMBANK_W = 8;
    localparam int ROMBANK_W = 6;

    // memory high address and shared low address widths
    localparam int MEM_ABH_W = 9;
    localparam int CPU_ABL_W = 12;

    // one CPU address word, two ways of looking at it
    typedef union packed {
        // region decode and memory address building
        struct packed {
            logic [3:0]           hi;
            logic [CPU_ABL_W-1:0] lo;
        } flat;
        // 0x9Fxx decode
        struct packed {
            logic [7:0] page;
            logic [3:0] grp;
            logic [3:0] regn;
        } io;
    } cpu_addr_u;

endpackage

`default_nettype wire

// File: cpu_addr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_addr_decoder (
    input  wire                            clk6x,
    input  wire                            resetn,
    // cycle phase pulses
    input  wire                            setup_cs_i,
    input  wire                            release_wr_i,
    input  wire                            release_cs_i,
    // cpu status, read high and vector pull low
    input  wire                            cpu_rw_i,
    input  wire                            cpu_vpu_i,
    input  wire bus_pkg::cpu_addr_u        cpu_addr_i,
    // current banks
    input  wire [bus_pkg::ROMBANK_W-1:0]   rombank_i,
    input  wire [bus_pkg::RAMBANK_W-1:0]   rambank_masked_i,
    // memory bus
    output logic [bus_pkg::MEM_ABH_W-1:0]  mem_abh_o,
    output logic [bus_pkg::CPU_ABL_W-1:0]  memcpu_abl_o,
    output logic                           sram_csn_o,
    output logic                           vera_csn_o,
    output logic                           aio_csn_o,
    output logic                           enet_csn_o,
    output logic                           mem_wrn_o,
    // internal slave requests
    output logic                           req_scrb_o,
    output logic                           req_via1_o,
    cpu_cycle_if.decoder                   cyc
);
    import bus_pkg::*;

    // decoded targets of the address on the bus now
    logic                 sel_bank;
    logic                 sel_sram;
    logic                 sel_vera;
    logic                 sel_aio;
    logic                 sel_enet;
    logic                 sel_via1;
    logic                 sel_scrb;
    // any external device selected
    logic                 ext_sel;
    // low for ROM, which is never written
    logic                 wr_ok;
    logic [MEM_ABH_W-1:0] abh_nxt;
    // ROM bank, forced to 0 on vector pull
    logic [4:0]           rom_bank;

    assign rom_bank = cpu_vpu_i ? rombank_i[4:0] : 5'd0;
    assign ext_sel  = sel_sram | sel_vera | sel_aio | sel_enet;

    // region decode, first match wins
    always_comb
    begin
        sel_bank = 1'b0;
        sel_sram = 1'b0;
        sel_vera = 1'b0;
        sel_aio  = 1'b0;
        sel_enet = 1'b0;
        sel_via1 = 1'b0;
        sel_scrb = 1'b0;
        wr_ok    = 1'b1;
        // default is base low memory
        abh_nxt  = {LOWMEM_PAGE, cpu_addr_i.flat.hi};
        if ((cpu_addr_i.flat.hi == 4'h0) && (cpu_addr_i.flat.lo[CPU_ABL_W-1:1] == '0))
        begin
            // 0x0000 RAMBANK, 0x0001 ROMBANK
            sel_bank = 1'b1;
        end
        else if (cpu_addr_i.flat.hi[3:2] == 2'b11)
        begin
            // 0xC000..0xFFFF, 16k ROM banks at the top of SRAM
            sel_sram = 1'b1;
            wr_ok    = 1'b0;
            abh_nxt  = {ROM_BANK_TOP, rom_bank, cpu_addr_i.flat.hi[1:0]};
        end
        else if (cpu_addr_i.flat.hi[3:1] == 3'b101)
        begin
            // 0xA000..0xBFFF, 8k RAM banks from the SRAM bottom
            sel_sram = 1'b1;
            abh_nxt  = {rambank_masked_i, cpu_addr_i.flat.hi[0]};
        end
        else if (cpu_addr_i.io.page == IO_PAGE)
        begin
            // I/O groups; unmapped groups select nothing
            if (cpu_addr_i.io.grp == IO_VIA1)
            begin
                sel_via1 = 1'b1;
            end
            else if (cpu_addr_i.io.grp[3:1] == IO_VERA_HI)
            begin
                sel_vera = 1'b1;
            end
            else if (cpu_addr_i.io.grp == IO_AURA)
            begin
                sel_aio = 1'b1;
            end
            else if (cpu_addr_i.io.grp == IO_SCRB)
            begin
                sel_scrb = 1'b1;
            end
            else if (cpu_addr_i.io.grp == IO_ENET)
            begin
                sel_enet = 1'b1;
            end
        end
        else
        begin
            sel_sram = 1'b1;
        end
    end

    // selects, strobes and requests
    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            sram_csn_o      <= INACT_HIGH;
            vera_csn_o      <= INACT_HIGH;
            aio_csn_o       <= INACT_HIGH;
            enet_csn_o      <= INACT_HIGH;
            mem_wrn_o       <= INACT_HIGH;
            cyc.mem_rdn     <= INACT_HIGH;
            req_scrb_o      <= 1'b0;
            req_via1_o      <= 1'b0;
            cyc.req_bankreg <= 1'b0;
        end
        else
        begin
            // drop write early, gives the write latch some hold before cs goes
            if (release_wr_i)
            begin
                mem_wrn_o <= INACT_HIGH;
            end
            // end of cpu cycle
            if (release_cs_i)
            begin
                sram_csn_o      <= INACT_HIGH;
                vera_csn_o      <= INACT_HIGH;
                aio_csn_o       <= INACT_HIGH;
                enet_csn_o      <= INACT_HIGH;
                mem_wrn_o       <= INACT_HIGH;
                cyc.mem_rdn     <= INACT_HIGH;
                req_scrb_o      <= 1'b0;
                req_via1_o      <= 1'b0;
                cyc.req_bankreg <= 1'b0;
            end
            // setup comes last, so it overrides a coincident release
            if (setup_cs_i)
            begin
                if (sel_sram)
                begin
                    sram_csn_o <= ACT_LOW;
                end
                if (sel_vera)
                begin
                    vera_csn_o <= ACT_LOW;
                end
                if (sel_aio)
                begin
                    aio_csn_o <= ACT_LOW;
                end
                if (sel_enet)
                begin
                    enet_csn_o <= ACT_LOW;
                end
                if (ext_sel)
                begin
                    cyc.mem_rdn <= cpu_rw_i ? ACT_LOW : INACT_HIGH;
                    mem_wrn_o   <= (!cpu_rw_i && wr_ok) ? ACT_LOW : INACT_HIGH;
                end
                if (sel_via1)
                begin
                    req_via1_o <= 1'b1;
                end
                if (sel_scrb)
                begin
                    req_scrb_o <= 1'b1;
                end
                if (sel_bank)
                begin
                    cyc.req_bankreg <= 1'b1;
                end
            end
        end
    end

    // latched address and direction
    always_ff @(posedge clk6x)
    begin
        if (setup_cs_i)
        begin
            // low 12 bits go through unchanged
            memcpu_abl_o <= cpu_addr_i.flat.lo;
            cyc.slv_addr <= cpu_addr_i;
            cyc.slv_rwn  <= cpu_rw_i;
            // high address only matters for SRAM cycles
            if (sel_sram)
            begin
                mem_abh_o <= abh_nxt;
            end
        end
    end

endmodule

`default_nettype wire

// File: cpu_cycle_if.sv
`timescale 1ns/1ns
`default_nettype none

interface cpu_cycle_if;
    import bus_pkg::*;

    // cpu address latched at setup_cs
    cpu_addr_u slv_addr;
    // direction of the latched cycle, read high
    logic      slv_rwn;
    // current cycle targets the bank registers
    logic      req_bankreg;
    // memory read strobe, active low
    logic      mem_rdn;

    // address decoder owns the cycle state
    modport decoder (
        output slv_addr,
        output slv_rwn,
        output req_bankreg,
        output mem_rdn
    );

    // bank registers watch for their write cycle
    modport banks (
        input slv_addr,
        input slv_rwn,
        input req_bankreg
    );

    // read data path picks its source
    modport reader (
        input mem_rdn,
        input req_bankreg,
        input slv_addr
    );

endinterface

`default_nettype wire

// File: cpu_read_path.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_read_path (
    input  wire                           clk6x,
    input  wire  [7:0]                    mem_db_i,
    input  wire  [7:0]                    slv_data_i,
    input  wire  [bus_pkg::RAMBANK_W-1:0] rambank_i,
    input  wire  [bus_pkg::ROMBANK_W-1:0] rombank_i,
    input  wire                           req_scrb_i,
    input  wire                           req_via1_i,
    cpu_cycle_if.reader                   cyc,
    output logic [7:0]                    cpu_db_o
);
    import bus_pkg::*;

    // bank register picked by address bit 0, ROMBANK zero-extended
    logic [RAMBANK_W-1:0] bank_rd;

    assign bank_rd = cyc.slv_addr.flat.lo[0] ? {{(RAMBANK_W-ROMBANK_W){1'b0}}, rombank_i}
                                             : rambank_i;

    // data to the cpu, refreshed every clock while a source is active
    always_ff @(posedge clk6x)
    begin
        if (cyc.mem_rdn == ACT_LOW)
        begin
            // external memory or device read
            cpu_db_o <= mem_db_i;
        end
        else if (cyc.req_bankreg)
        begin
            cpu_db_o <= bank_rd;
        end
        else if (req_scrb_i || req_via1_i)
        begin
            // internal slave
            cpu_db_o <= slv_data_i;
        end
    end

endmodule

`default_nettype wire

// File: tb_bus_controller.sv
`timescale 1ns/1ns
`default_nettype none

module tb_bus_controller;

    // 300 cpu cycles of 8 clocks plus reset and some slack
    localparam int NUM_CYCLES     = 300;
    localparam int TIMEOUT_CYCLES = NUM_CYCLES * 10;
    // source of the cpu read data
    localparam logic [1:0] SRC_NONE = 2'd0;
    localparam logic [1:0] SRC_MEM  = 2'd1;
    localparam logic [1:0] SRC_BANK = 2'd2;
    localparam logic [1:0] SRC_SLV  = 2'd3;
    // what the compare process looks at on the next falling edge
    localparam logic [1:0] CHK_NONE   = 2'd0;
    localparam logic [1:0] CHK_DECODE = 2'd1;
    localparam logic [1:0] CHK_WR     = 2'd2;
    localparam logic [1:0] CHK_IDLE   = 2'd3;

    logic        clk6x;
    logic        resetn;
    logic [7:0]  cpu_db_i;
    logic [3:0]  cpu_abh_i;
    logic [11:0] memcpu_abl_i;
    logic        cpu_vpu_i;
    logic        cpu_rw_i;
    logic [7:0]  mem_db_i;
    logic        setup_cs_i;
    logic        release_wr_i;
    logic        release_cs_i;
    logic [7:0]  nora_slv_data_i;
    logic [7:0]  rambank_mask_i;
    wire  [7:0]  cpu_db_o;
    wire  [8:0]  mem_abh_o;
    wire  [11:0] memcpu_abl_o;
    wire  [7:0]  mem_db_o;
    wire         mem_rdn_o;
    wire         mem_wrn_o;
    wire         sram_csn_o;
    wire         vera_csn_o;
    wire         aio_csn_o;
    wire         enet_csn_o;
    wire  [15:0] nora_slv_addr_o;
    wire  [7:0]  nora_slv_datawr_o;
    wire         nora_slv_datawr_valid_o;
    wire         nora_slv_req_scrb_o;
    wire         nora_slv_req_via1_o;
    wire         nora_slv_rwn_o;

    // bank register model fed by our own write cycles
    logic [7:0]  model_ram;
    logic [5:0]  model_rom;
    logic [31:0] lcg_state;
    logic [15:0] r;
    logic [15:0] addr;
    logic        rw;
    logic        vpu;
    logic [7:0]  mem_data;
    logic [7:0]  slv_data;
    logic [7:0]  wdata;
    // expected response of the current cycle
    logic [3:0]  exp_cs;
    logic        exp_rdn;
    logic        exp_wrn;
    logic        exp_via1;
    logic        exp_scrb;
    logic        exp_abh_used;
    logic [1:0]  exp_src;
    logic [8:0]  exp_abh;
    logic [7:0]  exp_db;
    logic [1:0]  chk;
    int          errors = 0;
    int          checks = 0;
    int          assert_fails;
    int          cycle_count = 0;

    bus_controller bus_controller_inst (.*);

    initial clk6x = 1'b0;
    always #10 clk6x = ~clk6x;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic draw_random(output logic [15:0] val);
        lcg_state = lcg_next(lcg_state);
        // upper half has the better period
        val = lcg_state[31:16];
    endtask

    // expected {sram, vera, aio, enet}, strobes, requests, abh and read source
    function automatic logic [19:0] expect_cycle(input logic [15:0] a, input logic rd,
                                                 input logic vp, input logic [7:0] ram_bank,
                                                 input logic [5:0] rom_bank,
                                                 input logic [7:0] mask);
        logic [3:0] cs;
        logic       rdn;
        logic       wrn;
        logic       via1;
        logic       scrb;
        logic       used;
        logic [1:0] src;
        logic [8:0] abh;
        cs   = 4'b1111;
        rdn  = 1'b1;
        wrn  = 1'b1;
        via1 = 1'b0;
        scrb = 1'b0;
        used = 1'b0;
        src  = SRC_NONE;
        abh  = '0;
        if (a <= 16'h0001)
        begin
            src = SRC_BANK;
        end
        else if (a >= 16'hC000)
        begin
            // vector pull always sees ROM bank 0
            cs[3] = 1'b0;
            used  = 1'b1;
            abh   = {2'b11, (vp ? rom_bank[4:0] : 5'd0), a[13:12]};
        end
        else if (a >= 16'hA000)
        begin
            cs[3] = 1'b0;
            used  = 1'b1;
            abh   = {ram_bank & mask, a[12]};
        end
        else if (a[15:8] == 8'h9F)
        begin
            case (a[7:4])
                4'h0:    via1 = 1'b1;
                4'h2:    cs[2] = 1'b0;
                4'h3:    cs[2] = 1'b0;
                4'h4:    cs[1] = 1'b0;
                4'h5:    scrb = 1'b1;
                4'h8:    cs[0] = 1'b0;
                default: src = SRC_NONE;
            endcase
        end
        else
        begin
            cs[3] = 1'b0;
            used  = 1'b1;
            abh   = {5'h17, a[15:12]};
        end
        if (cs != 4'b1111)
        begin
            src = SRC_MEM;
            rdn = !rd;
            // ROM is read-only
            wrn = rd || (a >= 16'hC000);
        end
        if (via1 || scrb)
        begin
            src = SRC_SLV;
        end
        return {cs, rdn, wrn, via1, scrb, used, src, abh};
    endfunction

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] want);
        checks++;
        assert (got === want)
        else
        begin
            errors++;
            $display("FAIL %s at %0t: got %h, expected %h", name, $time, got, want);
        end
    endtask

    // falling edge compare against the reference
    always @(negedge clk6x)
    begin
        if (chk == CHK_DECODE)
        begin
            compare_value("sram_csn_o", sram_csn_o, exp_cs[3]);
            compare_value("vera_csn_o", vera_csn_o, exp_cs[2]);
            compare_value("aio_csn_o", aio_csn_o, exp_cs[1]);
            compare_value("enet_csn_o", enet_csn_o, exp_cs[0]);
            compare_value("mem_rdn_o", mem_rdn_o, exp_rdn);
            compare_value("mem_wrn_o", mem_wrn_o, exp_wrn);
            compare_value("nora_slv_req_via1_o", nora_slv_req_via1_o, exp_via1);
            compare_value("nora_slv_req_scrb_o", nora_slv_req_scrb_o, exp_scrb);
            compare_value("memcpu_abl_o", memcpu_abl_o, addr[11:0]);
            compare_value("nora_slv_addr_o", nora_slv_addr_o, addr);
            compare_value("nora_slv_rwn_o", nora_slv_rwn_o, rw);
            if (exp_abh_used)
            begin
                compare_value("mem_abh_o", mem_abh_o, exp_abh);
            end
            if (rw && (exp_src != SRC_NONE))
            begin
                compare_value("cpu_db_o", cpu_db_o, exp_db);
            end
        end
        else if (chk == CHK_WR)
        begin
            compare_value("mem_wrn_o", mem_wrn_o, 1'b1);
            compare_value("nora_slv_datawr_valid_o", nora_slv_datawr_valid_o, 1'b1);
            compare_value("nora_slv_datawr_o", nora_slv_datawr_o, wdata);
            compare_value("mem_db_o", mem_db_o, wdata);
        end
        else if (chk == CHK_IDLE)
        begin
            compare_value("sram_csn_o", sram_csn_o, 1'b1);
            compare_value("vera_csn_o", vera_csn_o, 1'b1);
            compare_value("aio_csn_o", aio_csn_o, 1'b1);
            compare_value("enet_csn_o", enet_csn_o, 1'b1);
            compare_value("mem_rdn_o", mem_rdn_o, 1'b1);
            compare_value("mem_wrn_o", mem_wrn_o, 1'b1);
            compare_value("nora_slv_req_via1_o", nora_slv_req_via1_o, 1'b0);
            compare_value("nora_slv_req_scrb_o", nora_slv_req_scrb_o, 1'b0);
            compare_value("nora_slv_datawr_valid_o", nora_slv_datawr_valid_o, 1'b0);
        end
    end

    always @(posedge clk6x)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("run stopped: test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d  check errors: %0d", checks, errors);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial
    begin
        lcg_state       = 32'h2eb5;
        model_ram       = '0;
        model_rom       = '0;
        chk             = CHK_NONE;
        resetn          = 1'b0;
        cpu_db_i        = '0;
        cpu_abh_i       = '0;
        memcpu_abl_i    = '0;
        cpu_vpu_i       = 1'b1;
        cpu_rw_i        = 1'b1;
        mem_db_i        = '0;
        setup_cs_i      = 1'b0;
        release_wr_i    = 1'b0;
        release_cs_i    = 1'b0;
        nora_slv_data_i = '0;
        rambank_mask_i  = 8'hFF;
        repeat (7) @(negedge clk6x);
        // bus must be idle while still in reset
        chk <= CHK_IDLE;
        @(negedge clk6x);
        resetn <= 1'b1;
        chk    <= CHK_NONE;
        for (int n = 0; n < NUM_CYCLES; n++)
        begin
            draw_random(r);
            case (r[2:0])
                3'd0:    addr = {15'd0, r[3]};
                3'd1:    addr = {2'b11, r[15:2]};
                3'd2:    addr = {3'b101, r[15:3]};
                3'd3:    addr = {8'h9F, r[15:8]};
                3'd4:    addr = {8'h9F, (r[3] ? 4'h5 : 4'h0), r[11:8]};
                default:
                begin
                    draw_random(r);
                    addr = r;
                end
            endcase
            draw_random(r);
            rw  = r[0];
            // vector pull one time in four
            vpu = r[1] | r[2];
            rambank_mask_i <= r[15:8];
            {exp_cs, exp_rdn, exp_wrn, exp_via1, exp_scrb, exp_abh_used, exp_src, exp_abh} =
                expect_cycle(addr, rw, vpu, model_ram, model_rom, r[15:8]);
            draw_random(r);
            mem_data = r[7:0];
            slv_data = r[15:8];
            draw_random(r);
            wdata = r[7:0];
            case (exp_src)
                SRC_MEM:  exp_db = mem_data;
                SRC_BANK: exp_db = addr[0] ? {2'b00, model_rom} : model_ram;
                SRC_SLV:  exp_db = slv_data;
                default:  exp_db = 8'h00;
            endcase
            cpu_abh_i       <= addr[15:12];
            memcpu_abl_i    <= addr[11:0];
            cpu_rw_i        <= rw;
            cpu_vpu_i       <= vpu;
            mem_db_i        <= mem_data;
            nora_slv_data_i <= slv_data;
            cpu_db_i        <= wdata;
            @(negedge clk6x);
            setup_cs_i <= 1'b1;
            @(negedge clk6x);
            setup_cs_i <= 1'b0;
            @(negedge clk6x);
            chk <= CHK_DECODE;
            @(negedge clk6x);
            release_wr_i <= 1'b1;
            chk          <= CHK_WR;
            @(negedge clk6x);
            release_wr_i <= 1'b0;
            chk          <= CHK_NONE;
            @(negedge clk6x);
            release_cs_i <= 1'b1;
            chk          <= CHK_IDLE;
            @(negedge clk6x);
            release_cs_i <= 1'b0;
            chk          <= CHK_NONE;
            // bank write landed at release_wr
            if ((addr <= 16'h0001) && !rw)
            begin
                if (addr[0])
                begin
                    model_rom = wdata[5:0];
                end
                else
                begin
                    model_ram = wdata;
                end
            end
            @(negedge clk6x);
        end
        @(negedge clk6x);
        assert_fails = bus_controller_inst.bus_controller_chk_inst.fail_count;
        $display("checks: %0d  check errors: %0d  assertion errors: %0d",
                 checks, errors, assert_fails);
        if ((errors == 0) && (assert_fails == 0))
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
bus_pkg.sv
cpu_cycle_if.sv
cpu_addr_decoder.sv
bank_regs.sv
cpu_read_path.sv
bus_controller.sv
bus_controller_chk.sv
tb_bus_controller.sv
